/* include/band_doa_settings.svh */
`ifndef BAND_DOA_SETTINGS_SVH
`define BAND_DOA_SETTINGS_SVH

// input sample format
`define BD_DIN_WIDTH   16
`define BD_PARALLEL    4           // lanes per beat, power of two
`define BD_VECTOR_LEN  64          // fft channels per frame
`define BD_BANDS       4           // must divide VECTOR_LEN/PARALLEL

// scaler and accumulators
`define BD_SCALE_DROP  12          // low bits removed before accumulation
`define BD_ACC_WIDTH   20
`define BD_DOUT_WIDTH  32

// lane product: two squares of DIN+1 bit values, plus one bit for the sum
`define BD_PROD_WIDTH  (2*(`BD_DIN_WIDTH+1)+1)

// one bit of growth per adder tree level
`define BD_SUM_WIDTH   (`BD_PROD_WIDTH+$clog2(`BD_PARALLEL))

`endif

/* rtl/band_doa_pkg.sv */
`default_nettype none
`include "band_doa_settings.svh"

package band_doa_pkg;

    // products of one lane after the unitary transform
    typedef struct packed {
        logic signed [`BD_PROD_WIDTH-1:0] pow1;
        logic signed [`BD_PROD_WIDTH-1:0] pow2;
        logic signed [`BD_PROD_WIDTH-1:0] corr;
    } lane_prod_t;

    // lane products summed over all lanes of a beat
    typedef struct packed {
        logic signed [`BD_SUM_WIDTH-1:0] pow1;
        logic signed [`BD_SUM_WIDTH-1:0] pow2;
        logic signed [`BD_SUM_WIDTH-1:0] corr;
    } sum_t;

    typedef struct packed {
        logic signed [`BD_ACC_WIDTH-1:0] pow1;
        logic signed [`BD_ACC_WIDTH-1:0] pow2;
        logic signed [`BD_ACC_WIDTH-1:0] corr;
    } scaled_t;

    typedef enum logic [0:0] {
        SEQ_IDLE,
        SEQ_EMIT    // band totals going out
    } seq_state_t;

endpackage

`default_nettype wire

/* rtl/band_doa_ifs.sv */
`default_nettype none
`include "band_doa_settings.svh"

// per-lane products, correlator to adder tree
interface lane_bus_if;
    import band_doa_pkg::*;

    logic       valid;
    logic       frame_start;
    logic       new_acc;
    lane_prod_t lanes [`BD_PARALLEL];

    modport source (output valid, frame_start, new_acc, lanes);
    modport sink   (input valid, frame_start, new_acc, lanes);
endinterface

// summed products, adder tree to scaler
interface sum_bus_if;
    import band_doa_pkg::*;

    logic valid;
    logic frame_start;
    logic new_acc;
    sum_t sum;

    modport source (output valid, frame_start, new_acc, sum);
    modport sink   (input valid, frame_start, new_acc, sum);
endinterface

// accumulator format, scaler to band accumulator
interface scaled_bus_if;
    import band_doa_pkg::*;

    logic    valid;
    logic    frame_start;
    logic    new_acc;
    scaled_t val;

    modport source (output valid, frame_start, new_acc, val);
    modport sink   (input valid, frame_start, new_acc, val);
endinterface

`default_nettype wire

/* rtl/centrosym_corr.sv */
`default_nettype none
`include "band_doa_settings.svh"

module centrosym_corr (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire [`BD_PARALLEL*`BD_DIN_WIDTH-1:0] din1_re,
    input  wire [`BD_PARALLEL*`BD_DIN_WIDTH-1:0] din1_im,
    input  wire [`BD_PARALLEL*`BD_DIN_WIDTH-1:0] din2_re,
    input  wire [`BD_PARALLEL*`BD_DIN_WIDTH-1:0] din2_im,
    input  wire                                  din_valid,
    input  wire                                  frame_start,
    input  wire                                  new_acc,
    lane_bus_if.source                           out
);
    localparam int DW = `BD_DIN_WIDTH;
    localparam int NL = `BD_PARALLEL;

    // transformed pair per lane, one bit of growth
    logic signed [DW:0] y1_re [NL];
    logic signed [DW:0] y1_im [NL];
    logic signed [DW:0] y2_re [NL];
    logic signed [DW:0] y2_im [NL];
    logic               t_valid;
    logic               t_frame_start;
    logic               t_new_acc;

    // stage 1, unitary transform of the antenna pair
    always_ff @(posedge clk) begin
        for (int i = 0; i < NL; i++) begin
            y1_re[i] <= $signed(din1_re[i*DW +: DW]) + $signed(din2_re[i*DW +: DW]);
            y1_im[i] <= $signed(din1_im[i*DW +: DW]) + $signed(din2_im[i*DW +: DW]);
            y2_re[i] <= $signed(din1_im[i*DW +: DW]) - $signed(din2_im[i*DW +: DW]);
            y2_im[i] <= $signed(din2_re[i*DW +: DW]) - $signed(din1_re[i*DW +: DW]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            t_valid <= 1'b0;
        end else begin
            t_valid <= din_valid;
        end
        t_frame_start <= frame_start;
        t_new_acc     <= new_acc;
    end

    // stage 2, powers and real cross term
    always_ff @(posedge clk) begin
        for (int i = 0; i < NL; i++) begin
            out.lanes[i].pow1 <= y1_re[i] * y1_re[i] + y1_im[i] * y1_im[i];
            out.lanes[i].pow2 <= y2_re[i] * y2_re[i] + y2_im[i] * y2_im[i];
            out.lanes[i].corr <= y1_re[i] * y2_re[i] + y1_im[i] * y2_im[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= t_valid;
        end
        out.frame_start <= t_frame_start;
        out.new_acc     <= t_new_acc;
    end

    // integration may only restart on the first beat of a frame
    a_new_acc_on_frame: assert property (@(posedge clk) disable iff (rst)
        new_acc |-> frame_start)
        else $error("new_acc seen without frame_start");

    a_frame_on_valid: assert property (@(posedge clk) disable iff (rst)
        frame_start |-> din_valid)
        else $error("frame_start seen without din_valid");

endmodule

`default_nettype wire

/* rtl/lane_adder_tree.sv */
`default_nettype none
`include "band_doa_settings.svh"

module lane_adder_tree (
    input  wire       clk,
    input  wire       rst,
    lane_bus_if.sink  in,
    sum_bus_if.source out
);
    localparam int LEVELS = $clog2(`BD_PARALLEL);
    localparam int PW     = `BD_PROD_WIDTH;

    for (genvar l = 0; l < LEVELS; l++) begin : lvl
        localparam int N = `BD_PARALLEL >> (l + 1);    // adders on this level
        localparam int W = PW + l + 1;

        // operands, one bit narrower than this level's sums
        logic signed [W-2:0] a_pow1 [2*N];
        logic signed [W-2:0] a_pow2 [2*N];
        logic signed [W-2:0] a_corr [2*N];
        logic                a_valid;
        logic                a_frame_start;
        logic                a_new_acc;

        logic signed [W-1:0] pow1 [N];
        logic signed [W-1:0] pow2 [N];
        logic signed [W-1:0] corr [N];
        logic                valid;
        logic                frame_start;
        logic                new_acc;

        if (l == 0) begin : from_lanes
            always_comb begin
                for (int k = 0; k < 2*N; k++) begin
                    a_pow1[k] = in.lanes[k].pow1;
                    a_pow2[k] = in.lanes[k].pow2;
                    a_corr[k] = in.lanes[k].corr;
                end
                a_valid       = in.valid;
                a_frame_start = in.frame_start;
                a_new_acc     = in.new_acc;
            end
        end else begin : from_prev
            assign a_pow1        = lvl[l-1].pow1;
            assign a_pow2        = lvl[l-1].pow2;
            assign a_corr        = lvl[l-1].corr;
            assign a_valid       = lvl[l-1].valid;
            assign a_frame_start = lvl[l-1].frame_start;
            assign a_new_acc     = lvl[l-1].new_acc;
        end

        always_ff @(posedge clk) begin
            for (int k = 0; k < N; k++) begin
                pow1[k] <= a_pow1[2*k] + a_pow1[2*k+1];  // sign-extended pairwise
                pow2[k] <= a_pow2[2*k] + a_pow2[2*k+1];
                corr[k] <= a_corr[2*k] + a_corr[2*k+1];
            end
            if (rst) begin
                valid <= 1'b0;
            end else begin
                valid <= a_valid;
            end
            frame_start <= a_frame_start;
            new_acc     <= a_new_acc;
        end
    end

    assign out.sum.pow1    = lvl[LEVELS-1].pow1[0];
    assign out.sum.pow2    = lvl[LEVELS-1].pow2[0];
    assign out.sum.corr    = lvl[LEVELS-1].corr[0];
    assign out.valid       = lvl[LEVELS-1].valid;
    assign out.frame_start = lvl[LEVELS-1].frame_start;
    assign out.new_acc     = lvl[LEVELS-1].new_acc;

endmodule

`default_nettype wire

/* rtl/pre_acc_scale.sv */
`default_nettype none
`include "band_doa_settings.svh"

module pre_acc_scale (
    input  wire          clk,
    input  wire          rst,
    sum_bus_if.sink      in,
    scaled_bus_if.source out
);
    localparam int SW = `BD_SUM_WIDTH;
    localparam int AW = `BD_ACC_WIDTH;

    // signed limits of the accumulator format, held at the sum width
    localparam logic signed [SW-1:0] ACC_MAX = (2 ** (AW - 1)) - 1;
    localparam logic signed [SW-1:0] ACC_MIN = -(2 ** (AW - 1));

    function automatic logic signed [AW-1:0] drop_sat(input logic signed [SW-1:0] x);
        logic signed [SW-1:0] sh;
        sh = x >>> `BD_SCALE_DROP;
        if (sh > ACC_MAX) begin
            return ACC_MAX[AW-1:0];
        end else if (sh < ACC_MIN) begin
            return ACC_MIN[AW-1:0];
        end
        return sh[AW-1:0];
    endfunction

    always_ff @(posedge clk) begin
        out.val.pow1 <= drop_sat(in.sum.pow1);
        out.val.pow2 <= drop_sat(in.sum.pow2);
        out.val.corr <= drop_sat(in.sum.corr);   // cross term may go negative
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
        out.frame_start <= in.frame_start;
        out.new_acc     <= in.new_acc;
    end

endmodule

`default_nettype wire

/* rtl/band_accumulator.sv */
`default_nettype none
`include "band_doa_settings.svh"

module band_accumulator (
    input  wire                              clk,
    input  wire                              rst,
    scaled_bus_if.sink                       in,
    output logic signed [`BD_DOUT_WIDTH-1:0] r11,
    output logic signed [`BD_DOUT_WIDTH-1:0] r22,
    output logic signed [`BD_DOUT_WIDTH-1:0] r12,
    output logic                             dout_valid,
    output logic [$clog2(`BD_BANDS)-1:0]     band_number
);
    import band_doa_pkg::*;

    localparam int BEATS     = `BD_VECTOR_LEN / `BD_PARALLEL;
    localparam int BANDS     = `BD_BANDS;
    localparam int BAND_STEP = BEATS / BANDS;
    localparam int DW        = `BD_DOUT_WIDTH;
    localparam int CW        = $clog2(BEATS) + 1;    // room for one past the frame end
    localparam int BW        = $clog2(BANDS);

    logic [CW-1:0]        beat_cnt;     // index expected for the next beat
    logic [CW-1:0]        beat_idx;
    logic [BW-1:0]        band_sel;
    logic                 primed;       // an integration is running
    seq_state_t           state;
    logic signed [DW-1:0] v11;
    logic signed [DW-1:0] v22;
    logic signed [DW-1:0] v12;

    logic signed [DW-1:0] acc_r11 [BANDS];
    logic signed [DW-1:0] acc_r22 [BANDS];
    logic signed [DW-1:0] acc_r12 [BANDS];
    logic signed [DW-1:0] dump_r11 [BANDS];
    logic signed [DW-1:0] dump_r22 [BANDS];
    logic signed [DW-1:0] dump_r12 [BANDS];

    assign beat_idx = in.frame_start ? '0 : beat_cnt;
    assign band_sel = BW'(beat_idx / BAND_STEP);

    // sign extension to the accumulator width
    assign v11 = in.val.pow1;
    assign v22 = in.val.pow2;
    assign v12 = in.val.corr;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (in.valid) begin
            beat_cnt <= beat_idx + 1'b1;
        end
    end

    // per-band totals, wrapping at the output width
    always_ff @(posedge clk) begin
        if (in.valid) begin
            for (int b = 0; b < BANDS; b++) begin
                if (in.new_acc) begin
                    dump_r11[b] <= acc_r11[b];
                    dump_r22[b] <= acc_r22[b];
                    dump_r12[b] <= acc_r12[b];
                    acc_r11[b]  <= (b == band_sel) ? v11 : '0;
                    acc_r22[b]  <= (b == band_sel) ? v22 : '0;
                    acc_r12[b]  <= (b == band_sel) ? v12 : '0;
                end else if (b == band_sel) begin
                    acc_r11[b] <= acc_r11[b] + v11;
                    acc_r22[b] <= acc_r22[b] + v22;
                    acc_r12[b] <= acc_r12[b] + v12;
                end
            end
        end
    end

    // output sequencer, one band per cycle after each dump
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SEQ_IDLE;
            band_number <= '0;
            primed      <= 1'b0;
        end else if (in.valid && in.new_acc) begin
            primed      <= 1'b1;
            band_number <= '0;
            state       <= primed ? SEQ_EMIT : SEQ_IDLE;   // nothing completed yet
        end else if (state == SEQ_EMIT) begin
            if (band_number == BW'(BANDS - 1)) begin
                state       <= SEQ_IDLE;
                band_number <= '0;
            end else begin
                band_number <= band_number + 1'b1;
            end
        end
    end

    assign dout_valid = (state == SEQ_EMIT);
    assign r11        = dump_r11[band_number];
    assign r22        = dump_r22[band_number];
    assign r12        = dump_r12[band_number];

    a_beat_in_frame: assert property (@(posedge clk) disable iff (rst)
        in.valid && !in.frame_start |-> beat_cnt < BEATS)
        else $error("beat past frame end without frame_start");

    // a burst must finish before the dump register is overwritten
    a_dump_after_burst: assert property (@(posedge clk) disable iff (rst)
        in.valid && in.new_acc |-> state != SEQ_EMIT)
        else $error("new dump while band totals still going out");

endmodule

`default_nettype wire

/* rtl/band_doa_top.sv */
`default_nettype none
`include "band_doa_settings.svh"

module band_doa_top (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire [`BD_PARALLEL*`BD_DIN_WIDTH-1:0] din1_re,
    input  wire [`BD_PARALLEL*`BD_DIN_WIDTH-1:0] din1_im,
    input  wire [`BD_PARALLEL*`BD_DIN_WIDTH-1:0] din2_re,
    input  wire [`BD_PARALLEL*`BD_DIN_WIDTH-1:0] din2_im,
    input  wire                                  din_valid,
    input  wire                                  frame_start,
    input  wire                                  new_acc,
    output wire signed [`BD_DOUT_WIDTH-1:0]      r11,
    output wire signed [`BD_DOUT_WIDTH-1:0]      r22,
    output wire signed [`BD_DOUT_WIDTH-1:0]      r12,
    output wire                                  dout_valid,
    output wire [$clog2(`BD_BANDS)-1:0]          band_number
);
    lane_bus_if   lane_bus ();
    sum_bus_if    sum_bus ();
    scaled_bus_if scaled_bus ();

    // transform and products, +2
    centrosym_corr u_corr (
        .clk         (clk),
        .rst         (rst),
        .din1_re     (din1_re),
        .din1_im     (din1_im),
        .din2_re     (din2_re),
        .din2_im     (din2_im),
        .din_valid   (din_valid),
        .frame_start (frame_start),
        .new_acc     (new_acc),
        .out         (lane_bus.source)
    );

    lane_adder_tree u_tree (
        .clk (clk),
        .rst (rst),
        .in  (lane_bus.sink),
        .out (sum_bus.source)
    );

    pre_acc_scale u_scale (
        .clk (clk),
        .rst (rst),
        .in  (sum_bus.sink),
        .out (scaled_bus.source)
    );

    band_accumulator u_acc (
        .clk         (clk),
        .rst         (rst),
        .in          (scaled_bus.sink),
        .r11         (r11),
        .r22         (r22),
        .r12         (r12),
        .dout_valid  (dout_valid),
        .band_number (band_number)
    );

endmodule

`default_nettype wire

/* sim/band_doa_tb.sv */
`default_nettype none
`include "band_doa_settings.svh"

module band_doa_tb;
    localparam int     NL        = `BD_PARALLEL;
    localparam int     DW        = `BD_DIN_WIDTH;
    localparam int     BEATS     = `BD_VECTOR_LEN / `BD_PARALLEL;
    localparam int     BANDS     = `BD_BANDS;
    localparam int     BAND_STEP = BEATS / BANDS;
    localparam int     BW        = $clog2(BANDS);
    localparam int     OW        = `BD_DOUT_WIDTH;
    localparam longint ACC_MAX   = (longint'(1) << (`BD_ACC_WIDTH - 1)) - 1;
    localparam longint ACC_MIN   = -(longint'(1) << (`BD_ACC_WIDTH - 1));

    typedef struct packed {
        logic signed [OW-1:0] r11;
        logic signed [OW-1:0] r22;
        logic signed [OW-1:0] r12;
        logic [BW-1:0]        band;
        logic [31:0]          cyc;    // cycle of the expected output
        logic                 sat;
    } exp_t;

    logic                 clk;
    logic                 rst;
    logic [NL*DW-1:0]     din1_re;
    logic [NL*DW-1:0]     din1_im;
    logic [NL*DW-1:0]     din2_re;
    logic [NL*DW-1:0]     din2_im;
    logic                 din_valid;
    logic                 frame_start;
    logic                 new_acc;
    wire signed [OW-1:0]  r11;
    wire signed [OW-1:0]  r22;
    wire signed [OW-1:0]  r12;
    wire                  dout_valid;
    wire [BW-1:0]         band_number;

    logic [31:0]          seed;
    logic [31:0]          cyc;
    int                   errors;
    int                   err_mark;
    int                   n_exp;
    int                   n_out;
    exp_t                 exp_q[$];
    exp_t                 e;

    // reference model state
    logic signed [OW-1:0] m11 [BANDS];
    logic signed [OW-1:0] m22 [BANDS];
    logic signed [OW-1:0] m12 [BANDS];
    int                   m_beat;
    logic                 m_primed;
    logic                 m_sat;    // running integration uses full-scale data

    band_doa_top dut (
        .clk(clk), .rst(rst),
        .din1_re(din1_re), .din1_im(din1_im), .din2_re(din2_re), .din2_im(din2_im),
        .din_valid(din_valid), .frame_start(frame_start), .new_acc(new_acc),
        .r11(r11), .r22(r22), .r12(r12),
        .dout_valid(dout_valid), .band_number(band_number)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // drop the low bits, then clamp to the accumulator range
    function automatic logic signed [OW-1:0] to_acc_format(input longint s);
        longint sh;
        sh = s >>> `BD_SCALE_DROP;
        if (sh > ACC_MAX) sh = ACC_MAX;
        else if (sh < ACC_MIN) sh = ACC_MIN;
        return OW'(sh);
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("ERR %s got %h exp %h", name, got, want);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic push_totals(input logic [31:0] start);
        exp_t x;
        for (int k = 0; k < BANDS; k++) begin
            x.r11  = m11[k];
            x.r22  = m22[k];
            x.r12  = m12[k];
            x.band = BW'(k);
            x.cyc  = start + k;
            x.sat  = m_sat;
            exp_q.push_back(x);
            n_exp++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        din_valid   <= 1'b0;
        frame_start <= 1'b0;
        new_acc     <= 1'b0;
    endtask

    task automatic drive_beat(input logic fs, input logic na, input logic sat);
        logic signed [DW-1:0] x [4][NL];    // 1re, 1im, 2re, 2im per lane
        logic [31:0]          r;
        longint               y1r, y1i, y2r, y2i;
        longint               s1, s2, s12;
        int                   b;
        @(posedge clk);
        s1  = 0;
        s2  = 0;
        s12 = 0;
        for (int i = 0; i < NL; i++) begin
            for (int c = 0; c < 4; c++) begin
                r = lcg_next();
                if (sat) x[c][i] = (c < 2) ? 16'sh7fff : 16'sh8000;
                else x[c][i] = {{4{r[27]}}, r[27:16]};  // small magnitudes
            end
            y1r = longint'(x[0][i]) + longint'(x[2][i]);
            y1i = longint'(x[1][i]) + longint'(x[3][i]);
            y2r = longint'(x[1][i]) - longint'(x[3][i]);
            y2i = longint'(x[2][i]) - longint'(x[0][i]);
            s1  += y1r * y1r + y1i * y1i;
            s2  += y2r * y2r + y2i * y2i;
            s12 += y1r * y2r + y1i * y2i;
            din1_re[i*DW +: DW] <= x[0][i];
            din1_im[i*DW +: DW] <= x[1][i];
            din2_re[i*DW +: DW] <= x[2][i];
            din2_im[i*DW +: DW] <= x[3][i];
        end
        din_valid   <= 1'b1;
        frame_start <= fs;
        new_acc     <= na;
        if (fs) m_beat = 0;
        b = m_beat / BAND_STEP;
        if (na) begin
            if (m_primed) push_totals(cyc + 7);    // dump beat plus six edges
            m_primed = 1'b1;
            m_sat    = sat;
            for (int k = 0; k < BANDS; k++) begin
                m11[k] = '0;
                m22[k] = '0;
                m12[k] = '0;
            end
        end
        m11[b] = m11[b] + to_acc_format(s1);
        m22[b] = m22[b] + to_acc_format(s2);
        m12[b] = m12[b] + to_acc_format(s12);
        m_beat++;
    endtask

    task automatic drive_frame(input logic na, input logic sat, input logic gaps);
        logic [31:0] r;
        for (int k = 0; k < BEATS; k++) begin
            drive_beat(k == 0, na && k == 0, sat);
            if (gaps) begin
                r = lcg_next();
                repeat (r[31:30]) idle_cycle();
            end
        end
    endtask

    task automatic drain_outputs();
        int t;
        t = 0;
        idle_cycle();
        while (exp_q.size() != 0 && t < 200) begin
            idle_cycle();
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out waiting for %0d band outputs", exp_q.size());
            $display("sim failed");
            $finish;
        end
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    // outputs are compared half a cycle after the edge that sets them
    always @(negedge clk) begin
        if (rst) begin
            a_quiet_reset: assert (dout_valid === 1'b0)
                else note_failure("dout_valid high during reset");
        end else if (dout_valid === 1'b1) begin
            n_out++;
            a_expected: assert (exp_q.size() != 0)
                else note_failure("band output with no expected entry");
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                a_r11: assert (r11 == e.r11)
                    else show_mismatch("r11", r11, e.r11);
                a_r22: assert (r22 == e.r22)
                    else show_mismatch("r22", r22, e.r22);
                a_r12: assert (r12 == e.r12)
                    else show_mismatch("r12", r12, e.r12);
                a_band: assert (band_number == e.band)
                    else show_mismatch("band_number", band_number, e.band);
                a_cycle: assert (cyc == e.cyc)
                    else show_mismatch("dout_valid cycle", cyc, e.cyc);
                if (e.sat) begin
                    a_sat: assert (longint'(r22) == BAND_STEP * ACC_MAX)
                        else show_mismatch("r22", r22, OW'(BAND_STEP * ACC_MAX));
                end
            end
        end
    end

    a_band_step: assert property (@(posedge clk) disable iff (rst)
        dout_valid && band_number != BW'(BANDS - 1)
        |=> dout_valid && band_number == $past(band_number) + 1'b1)
        else note_failure("band burst broke off or skipped a band");

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cyc         = '0;
        din1_re     = '0;
        din1_im     = '0;
        din2_re     = '0;
        din2_im     = '0;
        din_valid   = 1'b0;
        frame_start = 1'b0;
        new_acc     = 1'b0;
        seed        = 32'h712df9b5;
        errors      = 0;
        err_mark    = 0;
        n_exp       = 0;
        n_out       = 0;
        m_beat      = 0;
        m_primed    = 1'b0;
        m_sat       = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        drive_frame(1'b1, 1'b0, 1'b0);    // first dump has nothing to emit
        drain_outputs();
        report(1, "reset and first integration");

        repeat (3) drive_frame(1'b1, 1'b0, 1'b0);
        drain_outputs();
        report(2, "one-frame integrations");

        drive_frame(1'b1, 1'b0, 1'b0);
        drive_frame(1'b0, 1'b0, 1'b0);
        drive_frame(1'b0, 1'b0, 1'b0);
        drive_frame(1'b1, 1'b0, 1'b0);    // closes the three-frame integration
        drain_outputs();
        report(3, "multi-frame integration");

        drive_frame(1'b1, 1'b0, 1'b1);
        drive_frame(1'b1, 1'b0, 1'b1);
        drain_outputs();
        report(4, "gaps in din_valid");

        drive_frame(1'b1, 1'b1, 1'b0);
        drive_frame(1'b1, 1'b0, 1'b0);
        drain_outputs();
        report(5, "saturation");

        drive_frame(1'b1, 1'b0, 1'b0);
        drain_outputs();
        repeat (2 * BANDS) idle_cycle();    // a stray band output would show up here
        a_all_matched: assert (n_out == n_exp)
            else note_failure("outputs and expected entries do not match up");
        report(6, "run summary");

        $display("tests 6, outputs %0d of %0d, errors %0d", n_out, n_exp, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* band_doa.f */
+incdir+include
rtl/band_doa_pkg.sv
rtl/band_doa_ifs.sv
rtl/centrosym_corr.sv
rtl/lane_adder_tree.sv
rtl/pre_acc_scale.sv
rtl/band_accumulator.sv
rtl/band_doa_top.sv
sim/band_doa_tb.sv
